/* Bender.yml */
package:
  name: int_divider

sources:
  - include_dirs:
      - logic
    files:
      - logic/div_pkg.sv
      - logic/div_operand_prep.sv
      - logic/div_radix_stage.sv
      - logic/div_result_fixup.sv
      - logic/div_ctrl.sv
      - logic/int_divider.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tb/tb_clk_gen.sv
      - tb/tb_int_divider.sv

/* int_divider.f */
+incdir+logic
logic/div_pkg.sv
logic/div_operand_prep.sv
logic/div_radix_stage.sv
logic/div_result_fixup.sv
logic/div_ctrl.sv
logic/int_divider.sv
tb/tb_clk_gen.sv
tb/tb_int_divider.sv

/* logic/div_ctrl.sv */
// Divider control FSM

`default_nettype none

`include "div_defines.svh"

module div_ctrl (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic start_i,
    input  logic neg_quot_i,
    input  logic neg_rem_i,
    input  logic sel_rem_i,
    output logic load_o,
    output logic step_o,
    output logic fix_o,
    output logic busy_o,
    output logic done_o,
    output logic neg_quot_o,
    output logic neg_rem_o,
    output logic sel_rem_o
);

    localparam int CNT_W = $clog2(`DIV_STEPS);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_STEP,
        ST_FIX,
        ST_DONE
    } state_t;

    state_t             state_q;
    state_t             state_nxt;
    logic [CNT_W-1:0]   step_cnt_q;
    logic               last_step;
    logic               accept;
    logic               done_q;
    logic               neg_quot_q;
    logic               neg_rem_q;
    logic               sel_rem_q;

    // start only counts while idle
    assign accept    = (state_q == ST_IDLE) & start_i;
    assign last_step = (step_cnt_q == CNT_W'(`DIV_STEPS - 1));

    // ========================================
    // next state
    // ========================================
    always_comb begin
        state_nxt = state_q;
        case (state_q)
            ST_IDLE: begin
                if (accept) begin
                    state_nxt = ST_STEP;
                end
            end
            ST_STEP: begin
                if (last_step) begin
                    state_nxt = ST_FIX;
                end
            end
            ST_FIX: begin
                state_nxt = ST_DONE;
            end
            // stay until the done pulse has been driven
            ST_DONE: begin
                if (done_q) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    // ========================================
    // state, counter and flags
    // ========================================
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q    <= ST_IDLE;
            step_cnt_q <= '0;
            done_q     <= 1'b0;
            neg_quot_q <= 1'b0;
            neg_rem_q  <= 1'b0;
            sel_rem_q  <= 1'b0;
        end else begin
            state_q <= state_nxt;
            // one cycle pulse on entering the done phase
            done_q  <= (state_q == ST_DONE) & ~done_q;
            if (accept) begin
                step_cnt_q <= '0;
                // operands may change once the division is running
                neg_quot_q <= neg_quot_i;
                neg_rem_q  <= neg_rem_i;
                sel_rem_q  <= sel_rem_i;
            end else if (state_q == ST_STEP) begin
                step_cnt_q <= step_cnt_q + 1'b1;
            end
        end
    end

    // stage captures operands on the accepting edge
    assign load_o = accept;
    assign step_o = (state_q == ST_STEP);
    assign fix_o  = (state_q == ST_FIX);
    assign busy_o = (state_q != ST_IDLE);
    assign done_o = done_q;

    assign neg_quot_o = neg_quot_q;
    assign neg_rem_o  = neg_rem_q;
    assign sel_rem_o  = sel_rem_q;

endmodule

`default_nettype wire

/* logic/div_defines.svh */
// Integer divider defines

`ifndef DIV_DEFINES_SVH
`define DIV_DEFINES_SVH

// ========================================
// datapath sizing
// ========================================

// operand and result width
`define DIV_XLEN 64

// quotient bits retired per step cycle
`define DIV_BITS_PER_STEP 8

// ========================================
// derived values
// ========================================

// step cycles for a full quotient
`define DIV_STEPS (`DIV_XLEN / `DIV_BITS_PER_STEP)

`endif

/* logic/div_operand_prep.sv */
// Divider operand preparation

`default_nettype none

module div_operand_prep (
    input  div_pkg::div_op_t op_i,
    input  div_pkg::bus64_t  dividend_i,
    input  div_pkg::bus64_t  divisor_i,
    output div_pkg::bus64_t  abs_dividend_o,
    output div_pkg::bus64_t  abs_divisor_o,
    output logic             neg_quot_o,
    output logic             neg_rem_o,
    output logic             sel_rem_o
);

    import div_pkg::*;

    logic is_signed;
    logic dividend_neg;
    logic divisor_neg;
    logic divisor_zero;

    // signed forms are DIV and REM
    assign is_signed = (op_i == DIV_OP_DIV) || (op_i == DIV_OP_REM);

    // remainder forms are REM and REMU
    assign sel_rem_o = (op_i == DIV_OP_REM) || (op_i == DIV_OP_REMU);

    // sign bits only count for signed forms
    assign dividend_neg = is_signed & dividend_i[$bits(bus64_t)-1];
    assign divisor_neg  = is_signed & divisor_i[$bits(bus64_t)-1];

    assign divisor_zero = (divisor_i == '0);

    // magnitudes for the unsigned core
    // the most negative value maps onto itself, which is its magnitude unsigned
    assign abs_dividend_o = dividend_neg ? -dividend_i : dividend_i;
    assign abs_divisor_o  = divisor_neg ? -divisor_i : divisor_i;

    // quotient sign flips on differing signs
    // a zero divisor keeps the all-ones quotient untouched
    assign neg_quot_o = (dividend_neg ^ divisor_neg) & ~divisor_zero;

    // remainder takes the sign of the dividend
    assign neg_rem_o = dividend_neg;

endmodule

`default_nettype wire

/* logic/div_pkg.sv */
// Integer divider types

`default_nettype none

`include "div_defines.svh"

package div_pkg;

    // ========================================
    // data types
    // ========================================

    // one full-width data word
    typedef logic [`DIV_XLEN-1:0] bus64_t;

    // operation codes
    // bit 1 selects the remainder, bit 0 selects unsigned
    typedef enum logic [1:0] {
        DIV_OP_DIV  = 2'b00,
        DIV_OP_DIVU = 2'b01,
        DIV_OP_REM  = 2'b10,
        DIV_OP_REMU = 2'b11
    } div_op_t;

endpackage

`default_nettype wire

/* logic/div_radix_stage.sv */
// Restoring division stage

`default_nettype none

`include "div_defines.svh"

module div_radix_stage (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            load_i,
    input  logic            step_i,
    input  div_pkg::bus64_t dividend_i,
    input  div_pkg::bus64_t divisor_i,
    output div_pkg::bus64_t quotient_o,
    output div_pkg::bus64_t remainder_o
);

    import div_pkg::*;

    // partial remainder
    bus64_t rem_q;
    // dividend shifts out at the top while quotient bits enter at the bottom
    bus64_t dq_q;
    bus64_t dvs_q;

    bus64_t rem_nxt;
    bus64_t dq_nxt;

    // ========================================
    // combinational compare-subtract chain
    // ========================================
    always_comb begin : chain
        // one spare bit, the shifted remainder can exceed the word
        logic [`DIV_XLEN:0] shifted;
        bus64_t             rem_v;
        bus64_t             dq_v;
        logic               q_bit;
        rem_v = rem_q;
        dq_v  = dq_q;
        for (int i = 0; i < `DIV_BITS_PER_STEP; i++) begin
            // bring down the next dividend bit
            shifted = {rem_v, dq_v[`DIV_XLEN-1]};
            q_bit   = (shifted >= {1'b0, dvs_q});
            if (q_bit) begin
                shifted = shifted - {1'b0, dvs_q};
            end
            // result is below the divisor so the spare bit is clear
            rem_v = shifted[`DIV_XLEN-1:0];
            dq_v  = {dq_v[`DIV_XLEN-2:0], q_bit};
        end
        rem_nxt = rem_v;
        dq_nxt  = dq_v;
    end

    // ========================================
    // working registers
    // ========================================
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rem_q <= '0;
            dq_q  <= '0;
            dvs_q <= '0;
        end else if (load_i) begin
            rem_q <= '0;
            dq_q  <= dividend_i;
            dvs_q <= divisor_i;
        end else if (step_i) begin
            rem_q <= rem_nxt;
            dq_q  <= dq_nxt;
        end
    end

    // after the last step the combined register is the whole quotient
    assign quotient_o  = dq_q;
    assign remainder_o = rem_q;

endmodule

`default_nettype wire

/* logic/div_result_fixup.sv */
// Divider sign fixup and result

`default_nettype none

module div_result_fixup (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            fix_i,
    input  div_pkg::bus64_t quotient_i,
    input  div_pkg::bus64_t remainder_i,
    input  logic            neg_quot_i,
    input  logic            neg_rem_i,
    input  logic            sel_rem_i,
    output div_pkg::bus64_t result_o
);

    import div_pkg::*;

    bus64_t quot_signed;
    bus64_t rem_signed;
    bus64_t result_sel;
    bus64_t result_q;

    // ========================================
    // sign correction
    // ========================================

    // two's complement negation of the unsigned magnitude
    assign quot_signed = neg_quot_i ? -quotient_i : quotient_i;
    assign rem_signed  = neg_rem_i ? -remainder_i : remainder_i;

    // REM and REMU take the remainder
    assign result_sel = sel_rem_i ? rem_signed : quot_signed;

    // ========================================
    // result register
    // ========================================

    // holds until the next division finishes
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            result_q <= '0;
        end else if (fix_i) begin
            result_q <= result_sel;
        end
    end

    assign result_o = result_q;

endmodule

`default_nettype wire

/* logic/int_divider.sv */
// Multi-cycle integer divider

`default_nettype none

module int_divider (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             start_i,
    input  div_pkg::div_op_t op_i,
    input  div_pkg::bus64_t  dividend_i,
    input  div_pkg::bus64_t  divisor_i,
    output logic             busy_o,
    output logic             done_o,
    output div_pkg::bus64_t  result_o
);

    import div_pkg::*;

    // prepared operands and flags, valid while start is high
    bus64_t abs_dividend;
    bus64_t abs_divisor;
    logic   neg_quot;
    logic   neg_rem;
    logic   sel_rem;

    // flags held for the whole division
    logic   neg_quot_lat;
    logic   neg_rem_lat;
    logic   sel_rem_lat;

    logic   load;
    logic   step;
    logic   fix;

    bus64_t quotient;
    bus64_t remainder;

    // ========================================
    // operand decode
    // ========================================
    div_operand_prep u_prep (
        .op_i           (op_i),
        .dividend_i     (dividend_i),
        .divisor_i      (divisor_i),
        .abs_dividend_o (abs_dividend),
        .abs_divisor_o  (abs_divisor),
        .neg_quot_o     (neg_quot),
        .neg_rem_o      (neg_rem),
        .sel_rem_o      (sel_rem)
    );

    // ========================================
    // control
    // ========================================
    div_ctrl u_ctrl (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .start_i    (start_i),
        .neg_quot_i (neg_quot),
        .neg_rem_i  (neg_rem),
        .sel_rem_i  (sel_rem),
        .load_o     (load),
        .step_o     (step),
        .fix_o      (fix),
        .busy_o     (busy_o),
        .done_o     (done_o),
        .neg_quot_o (neg_quot_lat),
        .neg_rem_o  (neg_rem_lat),
        .sel_rem_o  (sel_rem_lat)
    );

    // ========================================
    // datapath
    // ========================================
    div_radix_stage u_stage (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .load_i      (load),
        .step_i      (step),
        .dividend_i  (abs_dividend),
        .divisor_i   (abs_divisor),
        .quotient_o  (quotient),
        .remainder_o (remainder)
    );

    div_result_fixup u_fixup (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .fix_i       (fix),
        .quotient_i  (quotient),
        .remainder_i (remainder),
        .neg_quot_i  (neg_quot_lat),
        .neg_rem_i   (neg_rem_lat),
        .sel_rem_i   (sel_rem_lat),
        .result_o    (result_o)
    );

endmodule

`default_nettype wire

/* tb/tb_clk_gen.sv */
// Testbench clock and reset

`default_nettype none

module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    timeunit 1ns;
    timeprecision 1ps;

    // 20 ns period
    localparam int HALF_PERIOD = 10;
    localparam int RESET_CYCLES = 2;

    initial begin
        clk_o = 1'b0;
        forever begin
            #(HALF_PERIOD);
            clk_o = ~clk_o;
        end
    end

    // synchronous reset, released after the second rising edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

`default_nettype wire

/* tb/tb_int_divider.sv */
// Integer divider testbench

`default_nettype none

`include "div_defines.svh"

module tb_int_divider;

    timeunit 1ns;
    timeprecision 1ps;

    import div_pkg::*;

    // ========================================
    // run sizing
    // ========================================
    localparam int N_DIRECTED = 39;
    localparam int N_RANDOM = 200;
    localparam int N_OPS = N_DIRECTED + N_RANDOM;
    // accepting edge to done, steps plus fix plus done
    localparam int DONE_LAT = `DIV_STEPS + 2;
    localparam int CYCLE_LIMIT = N_OPS * (`DIV_STEPS + 4) + 50;
    localparam bus64_t MOST_NEG = {1'b1, {(`DIV_XLEN-1){1'b0}}};
    localparam bus64_t ALL_ONES = '1;

    logic    clk_i;
    logic    rst_n_i;
    logic    start_i;
    div_op_t op_i;
    bus64_t  dividend_i;
    bus64_t  divisor_i;
    logic    busy_o;
    logic    done_o;
    bus64_t  result_o;

    // expected results in issue order
    bus64_t      exp_q[$];
    bus64_t      cmp_exp;
    int          cycle_cnt = 0;
    int          accept_cyc;
    int          checked_cnt;
    logic        done_prev;
    logic [31:0] lfsr_state;

    tb_clk_gen u_clk_gen (
        .clk_o   (clk_i),
        .rst_n_o (rst_n_i)
    );

    int_divider UUT (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .start_i    (start_i),
        .op_i       (op_i),
        .dividend_i (dividend_i),
        .divisor_i  (divisor_i),
        .busy_o     (busy_o),
        .done_o     (done_o),
        .result_o   (result_o)
    );

    // ========================================
    // reference model and random source
    // ========================================

    // RISC-V M extension results, including the zero divisor and overflow rules
    function automatic bus64_t ref_div(input div_op_t op, input bus64_t a, input bus64_t b);
        logic signed [`DIV_XLEN-1:0] sa;
        logic signed [`DIV_XLEN-1:0] sb;
        logic                        ovf;
        sa  = a;
        sb  = b;
        ovf = (a == MOST_NEG) && (b == ALL_ONES);
        case (op)
            DIV_OP_DIV:  return (b == '0) ? ALL_ONES : (ovf ? MOST_NEG : bus64_t'(sa / sb));
            DIV_OP_DIVU: return (b == '0) ? ALL_ONES : a / b;
            DIV_OP_REM:  return (b == '0) ? a : (ovf ? '0 : bus64_t'(sa % sb));
            default:     return (b == '0) ? a : a % b;
        endcase
    endfunction

    // fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one LFSR step per bit taken
    task automatic draw_bits(input int n, output bus64_t val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[`DIV_XLEN-2:0], lfsr_state[0]};
        end
    endtask

    // ========================================
    // checks
    // ========================================
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_result(input bus64_t exp, input bus64_t act);
        if (act !== exp) begin
            $display("[FAIL] result_o expected 0x%h got 0x%h", exp, act);
            abort_run("result mismatch");
        end
    endtask

    task automatic check_latency(input int exp, input int act);
        if (act !== exp) begin
            $display("[FAIL] done_o latency expected 0x%0h got 0x%0h cycles", exp, act);
            abort_run("done pulse at the wrong cycle");
        end
    endtask

    task automatic check_level(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %s expected 0x%h got 0x%h", name, exp, act);
            abort_run("control output at the wrong level");
        end
    endtask

    // ========================================
    // stimulus
    // ========================================

    // start pulse, then wait for the matching done
    task automatic run_op(input div_op_t op, input bus64_t a, input bus64_t b);
        @(posedge clk_i);
        start_i    <= 1'b1;
        op_i       <= op;
        dividend_i <= a;
        divisor_i  <= b;
        exp_q.push_back(ref_div(op, a, b));
        @(posedge clk_i);
        start_i <= 1'b0;
        do begin
            @(negedge clk_i);
        end while (!done_o);
    endtask

    task automatic run_unsigned_pair(input bus64_t a, input bus64_t b);
        run_op(DIV_OP_DIVU, a, b);
        run_op(DIV_OP_REMU, a, b);
    endtask

    task automatic run_signed_pair(input bus64_t a, input bus64_t b);
        run_op(DIV_OP_DIV, a, b);
        run_op(DIV_OP_REM, a, b);
    endtask

    task automatic run_every_op(input bus64_t a, input bus64_t b);
        run_signed_pair(a, b);
        run_unsigned_pair(a, b);
    endtask

    // second start while busy must be dropped, new operands must not leak in
    task automatic run_with_ignored_start();
        @(posedge clk_i);
        start_i    <= 1'b1;
        op_i       <= DIV_OP_DIV;
        dividend_i <= -bus64_t'(1000);
        divisor_i  <= 64'd7;
        exp_q.push_back(ref_div(DIV_OP_DIV, -bus64_t'(1000), 64'd7));
        @(posedge clk_i);
        start_i <= 1'b0;
        repeat (3) @(negedge clk_i);
        check_level("busy_o", 1'b1, busy_o);
        @(posedge clk_i);
        start_i    <= 1'b1;
        op_i       <= DIV_OP_REMU;
        dividend_i <= 64'd55;
        divisor_i  <= 64'd0;
        @(posedge clk_i);
        start_i <= 1'b0;
        do begin
            @(negedge clk_i);
        end while (!done_o);
        // any late done is caught by the compare process
        repeat (2 * `DIV_STEPS) @(negedge clk_i);
    endtask

    task automatic run_random_ops(input int n);
        bus64_t bits;
        bus64_t a;
        bus64_t b;
        div_op_t op;
        for (int i = 0; i < n; i++) begin
            draw_bits(2, bits);
            op = div_op_t'(bits[1:0]);
            draw_bits(`DIV_XLEN, a);
            draw_bits(`DIV_XLEN, b);
            // shrink the divisor now and then for long quotients
            draw_bits(1, bits);
            if (bits[0]) begin
                draw_bits(6, bits);
                b = b >> bits[5:0];
            end
            // occasional zero divisor
            draw_bits(4, bits);
            if (bits[3:0] == 4'd0) begin
                b = '0;
            end
            run_op(op, a, b);
        end
    endtask

    // ========================================
    // cycle counter and compare process
    // ========================================
    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // sampled mid-cycle where all DUT outputs are settled
    always @(negedge clk_i) begin
        if (cycle_cnt > CYCLE_LIMIT) begin
            abort_run("timeout, the divider stopped answering");
        end
        if (rst_n_i) begin
            if (done_o) begin
                if (done_prev) begin
                    abort_run("done_o stayed high for more than one cycle");
                end
                if (exp_q.size() == 0) begin
                    abort_run("done_o pulsed with no division outstanding");
                end
                check_level("busy_o", 1'b1, busy_o);
                check_latency(DONE_LAT, cycle_cnt - accept_cyc);
                cmp_exp = exp_q.pop_front();
                check_result(cmp_exp, result_o);
                checked_cnt++;
            end
            // a start seen while idle is taken at the next rising edge
            if (start_i && !busy_o) begin
                accept_cyc = cycle_cnt + 1;
            end
            done_prev = done_o;
        end
    end

    // ========================================
    // test sequence
    // ========================================
    initial begin
        start_i     = 1'b0;
        op_i        = DIV_OP_DIV;
        dividend_i  = '0;
        divisor_i   = '0;
        accept_cyc  = 0;
        checked_cnt = 0;
        done_prev   = 1'b0;
        lfsr_state  = 32'h3d7050f5;

        wait (rst_n_i === 1'b1);
        @(negedge clk_i);
        check_level("busy_o", 1'b0, busy_o);
        check_level("done_o", 1'b0, done_o);
        check_result('0, result_o);

        // unsigned directed
        run_unsigned_pair(64'd100, 64'd7);
        run_unsigned_pair(64'd7, 64'd100);
        run_unsigned_pair(ALL_ONES, 64'd1);
        run_unsigned_pair(ALL_ONES, ALL_ONES);
        run_unsigned_pair(ALL_ONES, 64'd3);
        run_unsigned_pair(64'd0, 64'd5);
        run_unsigned_pair(64'h1234_5678_9abc_def0, 64'h1_0000);

        // signed directed, every sign combination
        run_signed_pair(64'd100, 64'd7);
        run_signed_pair(64'd100, -bus64_t'(7));
        run_signed_pair(-bus64_t'(100), 64'd7);
        run_signed_pair(-bus64_t'(100), -bus64_t'(7));
        run_signed_pair(ALL_ONES, 64'd2);
        run_signed_pair(MOST_NEG, 64'd2);

        // zero divisor and overflow corners
        run_every_op(64'd12345, 64'd0);
        run_every_op(-bus64_t'(12345), 64'd0);
        run_every_op(MOST_NEG, ALL_ONES);

        // control timing
        run_with_ignored_start();

        run_random_ops(N_RANDOM);

        repeat (2) @(negedge clk_i);
        if (checked_cnt == N_OPS && exp_q.size() == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            abort_run("not every issued division produced a result");
        end
    end

endmodule

`default_nettype wire
